/* include/font_rom.svh */
`ifndef FONT_ROM_SVH
`define FONT_ROM_SVH

// 8x16 glyphs, one byte per row, top row in the upper byte, msb is the left pixel
function automatic logic [127:0] font_glyph(input char_t c);
	case (c)
		".": font_glyph = 128'h00000000_00000000_00000000_60600000;
		"0": font_glyph = 128'h00000018_24424242_42424242_24180000;
		"1": font_glyph = 128'h00000008_38080808_08080808_083E0000;
		"2": font_glyph = 128'h0000003C_42424202_04081020_427E0000;
		"3": font_glyph = 128'h0000003C_42420204_18040242_423C0000;
		"4": font_glyph = 128'h00000004_0C0C1424_24447F04_041F0000;
		"5": font_glyph = 128'h0000007E_40404078_44020242_44380000;
		"6": font_glyph = 128'h00000018_2440405C_62424242_221C0000;
		"7": font_glyph = 128'h0000007E_42040408_08101010_10100000;
		"8": font_glyph = 128'h0000003C_42424224_18244242_423C0000;
		"9": font_glyph = 128'h00000038_44424242_463A0202_24180000;
		"A": font_glyph = 128'h00000010_10182828_243C4442_42E70000;
		"B": font_glyph = 128'h000000F8_44444478_44424242_44F80000;
		"C": font_glyph = 128'h0000003E_42428080_80808042_44380000;
		"D": font_glyph = 128'h000000F8_44424242_42424242_44F80000;
		"E": font_glyph = 128'h000000FC_42484878_48484042_42FC0000;
		"F": font_glyph = 128'h000000FC_42484878_48484040_40E00000;
		"G": font_glyph = 128'h0000003C_44448080_808E8444_44380000;
		"H": font_glyph = 128'h000000E7_42424242_7E424242_42E70000;
		"I": font_glyph = 128'h0000007C_10101010_10101010_107C0000;
		"J": font_glyph = 128'h0000003E_08080808_08080808_080888F0;
		"K": font_glyph = 128'h000000EE_44485070_50484844_44EE0000;
		"L": font_glyph = 128'h000000E0_40404040_40404040_42FE0000;
		"M": font_glyph = 128'h000000EE_6C6C6C6C_6C545454_54D60000;
		"N": font_glyph = 128'h000000C7_62625252_4A4A4A46_46E20000;
		"O": font_glyph = 128'h00000038_44828282_82828282_44380000;
		"P": font_glyph = 128'h000000FC_42424242_7C404040_40E00000;
		"Q": font_glyph = 128'h00000038_44828282_828282B2_4C380600;
		"R": font_glyph = 128'h000000FC_4242427C_48484444_42E30000;
		"S": font_glyph = 128'h0000003E_42424020_18040242_427C0000;
		"T": font_glyph = 128'h000000FE_92101010_10101010_10380000;
		"U": font_glyph = 128'h000000E7_42424242_42424242_423C0000;
		"V": font_glyph = 128'h000000E7_42424424_24282818_10100000;
		"W": font_glyph = 128'h000000D6_54545454_546C2828_28280000;
		"X": font_glyph = 128'h000000E7_42242418_18182424_42E70000;
		"Y": font_glyph = 128'h000000EE_44442828_10101010_10380000;
		"Z": font_glyph = 128'h0000007E_84040808_10202042_42FC0000;
		default: font_glyph = '0; // space and unknown codes
	endcase
endfunction

`endif

/* hdl/scope_lcd_pkg.sv */
package scope_lcd_pkg;

	localparam int scr_width = 480;
	localparam int scr_height = 320;
	localparam int plot_cols = 401;
	localparam int plot_rows = 256;

	typedef logic [16:0] lcd_word_t; // bit 16 high for data, low for command
	typedef logic [15:0] coord_t;
	typedef logic [7:0] char_t;
	typedef logic [13:0] ram_addr_t;
	typedef logic [7:0] sample_t;
	typedef logic [17:0] pix_count_t;

	localparam logic [15:0] col_black = 16'h0000;
	localparam logic [15:0] col_white = 16'hffff;
	localparam logic [15:0] col_yellow = 16'hffe0;
	localparam logic [15:0] col_blue = 16'h07ff;
	localparam logic [15:0] col_grey = 16'h6b4d;

	localparam logic [7:0] cmd_col_addr = 8'h2a;
	localparam logic [7:0] cmd_page_addr = 8'h2b;
	localparam logic [7:0] cmd_mem_write = 8'h2c;

	localparam int glyph_w = 8;
	localparam int glyph_h = 16;

	localparam int pixel_delay = 1;
	localparam int default_reset_delay = 10000000;
	localparam int init_len = 64;
	localparam int init_slow_idx_a = 0; // sleep out
	localparam int init_slow_idx_b = 62;

	localparam int label_len = 7;
	localparam char_t [label_len-1:0] label_text = "CH1 CH2";
	localparam int label_x = 402;
	localparam int label_y = 5;
	localparam int value_x = 402;
	localparam int value_y = 42;
	localparam int value_len = 6;

	// window writer owners
	localparam logic [1:0] own_clear = 2'd0;
	localparam logic [1:0] own_glyph = 2'd1;
	localparam logic [1:0] own_wave = 2'd2;

	// one extra row, the panel window is inclusive
	localparam pix_count_t clear_count = pix_count_t'(scr_width * (scr_height + 1));

	function automatic lcd_word_t lcd_cmd(input logic [7:0] c);
		return {1'b0, 8'h00, c};
	endfunction

	function automatic lcd_word_t lcd_dat(input logic [15:0] d);
		return {1'b1, d};
	endfunction

	function automatic logic grid_major_x(input logic [8:0] x);
		return x inside {9'd0, 9'd200, 9'd400};
	endfunction

	function automatic logic grid_major_y(input logic [7:0] y);
		return y inside {8'd0, 8'd127, 8'd255};
	endfunction

	function automatic logic grid_minor_x(input logic [8:0] x);
		return x inside {9'd50, 9'd100, 9'd150, 9'd250, 9'd300, 9'd350};
	endfunction

	function automatic logic grid_minor_y(input logic [7:0] y);
		return y inside {8'd31, 8'd63, 8'd95, 8'd159, 8'd191, 8'd223};
	endfunction

endpackage

/* hdl/lcd_bus_writer.sv */
`timescale 1ns/1ps

module lcd_bus_writer import scope_lcd_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic word_start,
	input  lcd_word_t word,
	input  logic [31:0] delay_cycles,
	output logic word_done,
	output logic lcd_cs,
	output logic lcd_dc,
	output logic lcd_rd,
	output logic lcd_wr,
	output logic [15:0] lcd_data
);

	logic busy;
	logic in_delay;
	logic [2:0] step;
	logic [31:0] dly_cnt;
	logic [31:0] dly_len;
	lcd_word_t word_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			in_delay <= 1'b0;
			step <= '0;
			dly_cnt <= '0;
			word_done <= 1'b0;
			lcd_cs <= 1'b1;
			lcd_dc <= 1'b1;
			lcd_rd <= 1'b1;
			lcd_wr <= 1'b1;
			lcd_data <= '0;
		end else begin
			word_done <= 1'b0;
			if (word_start && !busy) begin
				busy <= 1'b1;
				step <= 3'd1;
				word_q <= word;
				dly_len <= delay_cycles;
				lcd_dc <= word[16];
				lcd_rd <= 1'b1;
				lcd_cs <= 1'b0;
			end else if (busy && !in_delay) begin
				step <= step + 3'd1;
				case (step)
					3'd1: lcd_data <= word_q[15:0];
					3'd2: lcd_wr <= 1'b0;
					3'd3: lcd_wr <= 1'b1; // panel latches on this edge
					3'd4: lcd_cs <= 1'b1;
					default: begin
						in_delay <= 1'b1;
						dly_cnt <= '0;
					end
				endcase
			end else if (in_delay) begin
				if (dly_cnt == dly_len) begin
					in_delay <= 1'b0;
					busy <= 1'b0;
					word_done <= 1'b1;
				end else begin
					dly_cnt <= dly_cnt + 32'd1;
				end
			end
		end
	end

endmodule

/* hdl/lcd_power_up.sv */
`timescale 1ns/1ps

module lcd_power_up import scope_lcd_pkg::*; #(
	parameter int reset_delay = default_reset_delay
) (
	input  logic clk,
	input  logic rst_n,
	input  logic word_done,
	output logic lcd_res,
	output logic word_start,
	output lcd_word_t word,
	output logic [31:0] delay_cycles,
	output logic init_done
);

	localparam logic [31:0] res_cycles = 32'(reset_delay);

	// {dc, byte}
	localparam logic [8:0] init_rom [init_len] = '{
		9'h011, 9'h0F0, 9'h1C3, 9'h0F0, 9'h196, 9'h036, 9'h128, 9'h03A,
		9'h155, 9'h0B4, 9'h101, 9'h0B7, 9'h1C6, 9'h0E8, 9'h140, 9'h18A,
		9'h100, 9'h100, 9'h129, 9'h119, 9'h1A5, 9'h133, 9'h0C1, 9'h106,
		9'h0C2, 9'h1A7, 9'h0C5, 9'h118, 9'h0E0, 9'h1F0, 9'h109, 9'h10B, // e0 positive gamma
		9'h106, 9'h104, 9'h115, 9'h12F, 9'h154, 9'h142, 9'h13C, 9'h117,
		9'h114, 9'h118, 9'h11B, 9'h0E1, 9'h1F0, 9'h109, 9'h10B, 9'h106, // e1 negative gamma
		9'h104, 9'h103, 9'h12D, 9'h143, 9'h142, 9'h13B, 9'h116, 9'h114,
		9'h117, 9'h11B, 9'h0F0, 9'h13C, 9'h0F0, 9'h169, 9'h021, 9'h029  // ends with display on
	};

	typedef enum logic [2:0] {st_res_low, st_res_high, st_send, st_wait, st_done} state_t;

	state_t state;
	logic [31:0] cnt;
	logic [5:0] idx;
	logic [8:0] entry;
	logic slow;

	assign entry = init_rom[idx];
	assign slow = (idx == 6'(init_slow_idx_a)) || (idx == 6'(init_slow_idx_b));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_res_low;
			cnt <= '0;
			idx <= '0;
			lcd_res <= 1'b1;
			word_start <= 1'b0;
			init_done <= 1'b0;
		end else begin
			word_start <= 1'b0;
			case (state)
				st_res_low: begin
					if (cnt == res_cycles) begin
						lcd_res <= 1'b1;
						cnt <= '0;
						state <= st_res_high;
					end else begin
						lcd_res <= 1'b0;
						cnt <= cnt + 32'd1;
					end
				end
				st_res_high: begin
					if (cnt == res_cycles) state <= st_send;
					else cnt <= cnt + 32'd1;
				end
				st_send: begin
					word <= {entry[8], 8'h00, entry[7:0]};
					delay_cycles <= slow ? res_cycles : 32'(pixel_delay);
					word_start <= 1'b1;
					state <= st_wait;
				end
				st_wait: begin
					if (word_done) begin
						if (idx == 6'(init_len - 1)) begin
							init_done <= 1'b1;
							state <= st_done;
						end else begin
							idx <= idx + 6'd1;
							state <= st_send;
						end
					end
				end
				default: ;
			endcase
		end
	end

endmodule

/* hdl/lcd_window_writer.sv */
`timescale 1ns/1ps

module lcd_window_writer import scope_lcd_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic win_start,
	input  coord_t x_s,
	input  coord_t x_e,
	input  coord_t y_s,
	input  coord_t y_e,
	input  pix_count_t pixel_count,
	input  logic [15:0] pix_color,
	input  logic word_done,
	output logic pix_take,
	output logic win_done,
	output logic word_start,
	output lcd_word_t word,
	output logic [31:0] delay_cycles
);

	typedef enum logic [1:0] {st_idle, st_send, st_wait} state_t;

	state_t state;
	logic [3:0] idx; // 0..10 address words, 11 pixel stream
	pix_count_t left;
	coord_t xs_q;
	coord_t xe_q;
	coord_t ys_q;
	coord_t ye_q;
	lcd_word_t addr_word;

	assign delay_cycles = 32'(pixel_delay);

	always_comb begin
		case (idx)
			4'd0: addr_word = lcd_cmd(cmd_col_addr);
			4'd1: addr_word = lcd_dat({8'h00, xs_q[15:8]});
			4'd2: addr_word = lcd_dat({8'h00, xs_q[7:0]});
			4'd3: addr_word = lcd_dat({8'h00, xe_q[15:8]});
			4'd4: addr_word = lcd_dat({8'h00, xe_q[7:0]});
			4'd5: addr_word = lcd_cmd(cmd_page_addr);
			4'd6: addr_word = lcd_dat({8'h00, ys_q[15:8]});
			4'd7: addr_word = lcd_dat({8'h00, ys_q[7:0]});
			4'd8: addr_word = lcd_dat({8'h00, ye_q[15:8]});
			4'd9: addr_word = lcd_dat({8'h00, ye_q[7:0]});
			default: addr_word = lcd_cmd(cmd_mem_write);
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			idx <= '0;
			left <= '0;
			word_start <= 1'b0;
			pix_take <= 1'b0;
			win_done <= 1'b0;
		end else begin
			word_start <= 1'b0;
			pix_take <= 1'b0;
			win_done <= 1'b0;
			case (state)
				st_idle: begin
					if (win_start) begin
						xs_q <= x_s;
						xe_q <= x_e;
						ys_q <= y_s;
						ye_q <= y_e;
						left <= pixel_count;
						idx <= '0;
						state <= st_send;
					end
				end
				st_send: begin
					word_start <= 1'b1;
					if (idx == 4'd11) begin
						word <= lcd_dat(pix_color);
						pix_take <= 1'b1; // client moves to the next color
						left <= left - 1'b1;
					end else begin
						word <= addr_word;
					end
					state <= st_wait;
				end
				default: begin
					if (word_done) begin
						if (idx != 4'd11) begin
							idx <= idx + 4'd1;
							state <= st_send;
						end else if (left == '0) begin
							win_done <= 1'b1;
							state <= st_idle;
						end else begin
							state <= st_send;
						end
					end
				end
			endcase
		end
	end

endmodule

/* hdl/glyph_renderer.sv */
`timescale 1ns/1ps

module glyph_renderer import scope_lcd_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic text_start,
	input  char_t [6:0] text,
	input  logic [2:0] text_len,
	input  coord_t x_s,
	input  coord_t y_s,
	input  logic win_done,
	input  logic pix_take,
	output logic win_start,
	output coord_t win_x_s,
	output coord_t win_x_e,
	output coord_t win_y_s,
	output coord_t win_y_e,
	output logic [15:0] pix_color,
	output logic text_done
);

	`include "font_rom.svh"

	typedef enum logic [1:0] {st_idle, st_load, st_draw} state_t;

	state_t state;
	char_t [6:0] text_q;
	logic [2:0] ci; // counts down, first char sits highest
	logic [127:0] bits;
	coord_t x_q;
	coord_t y_q;

	assign win_x_s = x_q;
	assign win_x_e = x_q + coord_t'(glyph_w - 1);
	assign win_y_s = y_q;
	assign win_y_e = y_q + coord_t'(glyph_h - 1);
	assign pix_color = bits[127] ? col_white : col_black;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			ci <= '0;
			win_start <= 1'b0;
			text_done <= 1'b0;
		end else begin
			win_start <= 1'b0;
			text_done <= 1'b0;
			case (state)
				st_idle: begin
					if (text_start) begin
						text_q <= text;
						ci <= text_len - 3'd1;
						x_q <= x_s;
						y_q <= y_s;
						state <= st_load;
					end
				end
				st_load: begin
					bits <= font_glyph(text_q[ci]);
					win_start <= 1'b1;
					state <= st_draw;
				end
				default: begin
					if (pix_take) bits <= {bits[126:0], 1'b0};
					if (win_done) begin
						if (ci == '0) begin
							text_done <= 1'b1;
							state <= st_idle;
						end else begin
							ci <= ci - 3'd1;
							x_q <= x_q + coord_t'(glyph_w);
							state <= st_load;
						end
					end
				end
			endcase
		end
	end

endmodule

/* hdl/wave_plotter.sv */
`timescale 1ns/1ps

module wave_plotter import scope_lcd_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic wave_start,
	input  ram_addr_t trig_pos,
	input  logic [15:0] step,
	input  sample_t ram_data_a,
	input  sample_t ram_data_b,
	input  logic win_done,
	input  logic pix_take,
	output ram_addr_t ram_addr,
	output logic ram_en,
	output logic win_start,
	output coord_t win_x_s,
	output coord_t win_y_s,
	output logic [15:0] pix_color,
	output logic wave_done
);

	typedef enum logic [1:0] {st_idle, st_fetch, st_latch, st_paint} state_t;

	state_t state;
	ram_addr_t start_addr;
	logic [8:0] col;
	logic [7:0] row;
	sample_t ya;
	sample_t yb;

	assign win_x_s = coord_t'(col) + 16'd1;
	assign win_y_s = '0;

	always_comb begin
		if (row == ya) pix_color = col_yellow;
		else if (row == yb) pix_color = col_blue;
		else if (grid_major_x(col) || grid_major_y(row)) pix_color = col_white;
		else if (grid_minor_x(col) || grid_minor_y(row)) pix_color = col_grey;
		else pix_color = col_black;
	end

	// 201 columns of history before the trigger point
	always_ff @(posedge clk) begin
		start_addr <= trig_pos - ram_addr_t'(step * 16'd201);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			col <= '0;
			row <= '0;
			ram_addr <= '0;
			ram_en <= 1'b0;
			win_start <= 1'b0;
			wave_done <= 1'b0;
		end else begin
			win_start <= 1'b0;
			wave_done <= 1'b0;
			case (state)
				st_idle: begin
					if (wave_start) begin
						ram_addr <= start_addr;
						ram_en <= 1'b1;
						col <= '0;
						state <= st_fetch;
					end
				end
				st_fetch: state <= st_latch; // ram read latency
				st_latch: begin
					ya <= 8'd255 - ram_data_a; // screen y grows downward
					yb <= 8'd255 - ram_data_b;
					row <= '0;
					win_start <= 1'b1;
					state <= st_paint;
				end
				default: begin
					if (pix_take) row <= row + 8'd1;
					if (win_done) begin
						if (col == 9'(plot_cols - 1)) begin
							ram_en <= 1'b0;
							wave_done <= 1'b1;
							state <= st_idle;
						end else begin
							col <= col + 9'd1;
							ram_addr <= ram_addr + step[13:0];
							state <= st_fetch;
						end
					end
				end
			endcase
		end
	end

endmodule

/* hdl/display_sequencer.sv */
`timescale 1ns/1ps

module display_sequencer import scope_lcd_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic display_en,
	input  logic init_done,
	input  logic win_done,
	input  logic text_done,
	input  logic wave_done,
	output logic [1:0] owner,
	output logic clear_start,
	output logic text_start,
	output logic text_sel,
	output logic wave_start,
	output logic display_done
);

	typedef enum logic [2:0] {
		st_init, st_clear, st_label, st_idle, st_wave, st_value
	} state_t;

	state_t state;
	logic en_meta;
	logic en_sync;

	// display_en comes from another clock domain
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_meta <= 1'b0;
			en_sync <= 1'b0;
		end else begin
			en_meta <= display_en;
			en_sync <= en_meta;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_init;
			owner <= own_clear;
			clear_start <= 1'b0;
			text_start <= 1'b0;
			text_sel <= 1'b0;
			wave_start <= 1'b0;
			display_done <= 1'b0;
		end else begin
			clear_start <= 1'b0;
			text_start <= 1'b0;
			wave_start <= 1'b0;
			display_done <= 1'b0;
			case (state)
				st_init: begin
					if (init_done) begin
						owner <= own_clear;
						clear_start <= 1'b1;
						state <= st_clear;
					end
				end
				st_clear: begin
					if (win_done) begin
						owner <= own_glyph;
						text_sel <= 1'b0; // static label
						text_start <= 1'b1;
						state <= st_label;
					end
				end
				st_label: if (text_done) state <= st_idle;
				st_idle: begin
					if (en_sync) begin
						owner <= own_wave;
						wave_start <= 1'b1;
						state <= st_wave;
					end
				end
				st_wave: begin
					if (wave_done) begin
						owner <= own_glyph;
						text_sel <= 1'b1;
						text_start <= 1'b1;
						state <= st_value;
					end
				end
				default: begin
					if (text_done) begin
						display_done <= 1'b1;
						state <= st_idle;
					end
				end
			endcase
		end
	end

endmodule

/* hdl/scope_lcd_top.sv */
`timescale 1ns/1ps

module scope_lcd_top import scope_lcd_pkg::*; #(
	parameter int reset_delay = default_reset_delay
) (
	input  logic clk,
	input  logic rst_n,
	input  logic display_en,
	input  ram_addr_t trig_pos,
	input  logic [15:0] step,
	input  sample_t ram_data_a,
	input  sample_t ram_data_b,
	input  char_t [value_len-1:0] value_text,
	output logic lcd_res,
	output logic lcd_cs,
	output logic lcd_dc,
	output logic lcd_rd,
	output logic lcd_wr,
	output logic [15:0] lcd_data,
	output ram_addr_t ram_addr,
	output logic ram_en,
	output logic display_done
);

	logic bw_start;
	lcd_word_t bw_word;
	logic [31:0] bw_delay;
	logic word_done;
	logic pu_start;
	lcd_word_t pu_word;
	logic [31:0] pu_delay;
	logic init_done;
	logic ww_start;
	lcd_word_t ww_word;
	logic [31:0] ww_delay;

	logic win_start;
	logic win_done;
	logic pix_take;
	coord_t win_x_s;
	coord_t win_x_e;
	coord_t win_y_s;
	coord_t win_y_e;
	pix_count_t pixel_count;
	logic [15:0] pix_color;

	logic [1:0] owner;
	logic clear_start;
	logic text_start;
	logic text_sel;
	logic text_done;
	logic wave_start;
	logic wave_done;

	char_t [6:0] text;
	logic [2:0] text_len;
	coord_t text_x;
	coord_t text_y;
	logic g_win_start;
	coord_t g_x_s;
	coord_t g_x_e;
	coord_t g_y_s;
	coord_t g_y_e;
	logic [15:0] g_color;
	logic w_win_start;
	coord_t w_x_s;
	coord_t w_y_s;
	logic [15:0] w_color;

	// power-up sequencer holds the bus until the table is out
	assign bw_start = init_done ? ww_start : pu_start;
	assign bw_word = init_done ? ww_word : pu_word;
	assign bw_delay = init_done ? ww_delay : pu_delay;

	assign text = text_sel ? {8'h20, value_text} : label_text;
	assign text_len = text_sel ? 3'(value_len) : 3'(label_len);
	assign text_x = text_sel ? coord_t'(value_x) : coord_t'(label_x);
	assign text_y = text_sel ? coord_t'(value_y) : coord_t'(label_y);

	always_comb begin
		case (owner)
			own_glyph: begin
				win_start = g_win_start;
				win_x_s = g_x_s;
				win_x_e = g_x_e;
				win_y_s = g_y_s;
				win_y_e = g_y_e;
				pixel_count = pix_count_t'(glyph_w * glyph_h);
				pix_color = g_color;
			end
			own_wave: begin
				win_start = w_win_start;
				win_x_s = w_x_s;
				win_x_e = w_x_s; // one column wide
				win_y_s = w_y_s;
				win_y_e = coord_t'(plot_rows - 1);
				pixel_count = pix_count_t'(plot_rows);
				pix_color = w_color;
			end
			default: begin
				win_start = clear_start;
				win_x_s = '0;
				win_x_e = coord_t'(scr_width);
				win_y_s = '0;
				win_y_e = coord_t'(scr_height);
				pixel_count = clear_count;
				pix_color = col_black;
			end
		endcase
	end

	lcd_bus_writer u_bus (
		.clk(clk), .rst_n(rst_n),
		.word_start(bw_start), .word(bw_word), .delay_cycles(bw_delay),
		.word_done(word_done),
		.lcd_cs(lcd_cs), .lcd_dc(lcd_dc), .lcd_rd(lcd_rd), .lcd_wr(lcd_wr),
		.lcd_data(lcd_data)
	);

	lcd_power_up #(.reset_delay(reset_delay)) u_power_up (
		.clk(clk), .rst_n(rst_n), .word_done(word_done),
		.lcd_res(lcd_res), .word_start(pu_start), .word(pu_word),
		.delay_cycles(pu_delay), .init_done(init_done)
	);

	lcd_window_writer u_window (
		.clk(clk), .rst_n(rst_n), .win_start(win_start),
		.x_s(win_x_s), .x_e(win_x_e), .y_s(win_y_s), .y_e(win_y_e),
		.pixel_count(pixel_count), .pix_color(pix_color), .word_done(word_done),
		.pix_take(pix_take), .win_done(win_done),
		.word_start(ww_start), .word(ww_word), .delay_cycles(ww_delay)
	);

	glyph_renderer u_glyph (
		.clk(clk), .rst_n(rst_n), .text_start(text_start),
		.text(text), .text_len(text_len), .x_s(text_x), .y_s(text_y),
		.win_done(win_done), .pix_take(pix_take),
		.win_start(g_win_start), .win_x_s(g_x_s), .win_x_e(g_x_e),
		.win_y_s(g_y_s), .win_y_e(g_y_e), .pix_color(g_color), .text_done(text_done)
	);

	wave_plotter u_wave (
		.clk(clk), .rst_n(rst_n), .wave_start(wave_start),
		.trig_pos(trig_pos), .step(step),
		.ram_data_a(ram_data_a), .ram_data_b(ram_data_b),
		.win_done(win_done), .pix_take(pix_take),
		.ram_addr(ram_addr), .ram_en(ram_en), .win_start(w_win_start),
		.win_x_s(w_x_s), .win_y_s(w_y_s), .pix_color(w_color), .wave_done(wave_done)
	);

	display_sequencer u_seq (
		.clk(clk), .rst_n(rst_n), .display_en(display_en), .init_done(init_done),
		.win_done(win_done), .text_done(text_done), .wave_done(wave_done),
		.owner(owner), .clear_start(clear_start), .text_start(text_start),
		.text_sel(text_sel), .wave_start(wave_start), .display_done(display_done)
	);

endmodule

/* tests/scope_lcd_asserts.sv */
`timescale 1ns/1ps

module scope_lcd_asserts (
	input logic clk,
	input logic rst_n,
	input logic word_start,
	input logic busy,
	input logic word_done,
	input logic lcd_cs,
	input logic lcd_wr,
	input logic [31:0] delay_cycles
);

	logic [31:0] elapsed;
	logic [31:0] dly_q;
	int fail_count = 0;

	// cycles since the last accepted word
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			elapsed <= '0;
			dly_q <= '0;
		end else if (word_start && !busy) begin
			elapsed <= 32'd1;
			dly_q <= delay_cycles;
		end else begin
			elapsed <= elapsed + 32'd1;
		end
	end

	start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		word_start |-> !busy)
		else begin
			fail_count++;
			$error("word_start while the bus writer is busy");
		end

	wr_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(lcd_wr) |=> lcd_wr)
		else begin
			fail_count++;
			$error("wr held low for more than one cycle");
		end

	wr_inside_cs: assert property (@(posedge clk) disable iff (!rst_n)
		!lcd_wr |-> !lcd_cs)
		else begin
			fail_count++;
			$error("wr low while cs is high");
		end

	done_latency: assert property (@(posedge clk) disable iff (!rst_n)
		word_done |-> elapsed == dly_q + 32'd7)
		else begin
			fail_count++;
			$error("word_done not 7 + delay cycles after word_start");
		end

endmodule

bind lcd_bus_writer scope_lcd_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.word_start(word_start),
	.busy(busy),
	.word_done(word_done),
	.lcd_cs(lcd_cs),
	.lcd_wr(lcd_wr),
	.delay_cycles(delay_cycles)
);

/* tests/tb_scope_lcd.sv */
`timescale 1ns/1ps

module tb_scope_lcd import scope_lcd_pkg::*; ();

	logic clk;
	logic rst_n;
	logic display_en;
	ram_addr_t trig_pos;
	logic [15:0] step;
	sample_t ram_data_a = '0;
	sample_t ram_data_b = '0;
	char_t [value_len-1:0] value_text;
	logic lcd_res;
	logic lcd_cs;
	logic lcd_dc;
	logic lcd_rd;
	logic lcd_wr;
	logic [15:0] lcd_data;
	ram_addr_t ram_addr;
	logic ram_en;
	logic display_done;

	sample_t ram_a [16384];
	sample_t ram_b [16384];
	ram_addr_t addr_q;
	logic [31:0] lfsr = 32'h17ef454a;
	logic [16:0] bus_words [$]; // {dc, data} per write strobe
	logic [15:0] screen [262144]; // y * 512 + x
	int win_xs = 0;
	int win_xe = 0;
	int win_ys = 0;
	int win_ye = 0;
	int wx = 0;
	int wy = 0;
	int arg_idx = 0;
	logic [7:0] cur_cmd = 8'h00;
	logic [7:0] arg_hi = 8'h00;
	string test_name = "setup";

	// {dc, byte} as the panel expects it after reset
	logic [8:0] init_table [64] = '{
		9'h011, 9'h0F0, 9'h1C3, 9'h0F0, 9'h196, 9'h036, 9'h128, 9'h03A,
		9'h155, 9'h0B4, 9'h101, 9'h0B7, 9'h1C6, 9'h0E8, 9'h140, 9'h18A,
		9'h100, 9'h100, 9'h129, 9'h119, 9'h1A5, 9'h133, 9'h0C1, 9'h106,
		9'h0C2, 9'h1A7, 9'h0C5, 9'h118, 9'h0E0, 9'h1F0, 9'h109, 9'h10B,
		9'h106, 9'h104, 9'h115, 9'h12F, 9'h154, 9'h142, 9'h13C, 9'h117,
		9'h114, 9'h118, 9'h11B, 9'h0E1, 9'h1F0, 9'h109, 9'h10B, 9'h106,
		9'h104, 9'h103, 9'h12D, 9'h143, 9'h142, 9'h13B, 9'h116, 9'h114,
		9'h117, 9'h11B, 9'h0F0, 9'h13C, 9'h0F0, 9'h169, 9'h021, 9'h029
	};

	scope_lcd_top #(.reset_delay(20)) dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// capture RAM, one cycle read
	always @(posedge clk) addr_q <= ram_addr;
	always @(negedge clk) begin
		ram_data_a <= ram_a[addr_q];
		ram_data_b <= ram_b[addr_q];
	end

	// panel model fed by each rising wr
	always @(posedge lcd_wr) begin
		if (rst_n === 1'b1) begin
			bus_words.push_back({lcd_dc, lcd_data});
			check_eq("rd during write", 1, lcd_rd);
			if (!lcd_dc) begin
				cur_cmd = lcd_data[7:0];
				arg_idx = 0;
				wx = win_xs;
				wy = win_ys;
			end else if (cur_cmd == cmd_mem_write) begin
				if (wx < 512 && wy < 512) screen[wy * 512 + wx] = lcd_data;
				wx++;
				if (wx > win_xe) begin // wrap to the next row
					wx = win_xs;
					wy++;
					if (wy > win_ye) wy = win_ys;
				end
			end else if (cur_cmd == cmd_col_addr || cur_cmd == cmd_page_addr) begin
				if (arg_idx == 0 || arg_idx == 2) arg_hi = lcd_data[7:0];
				else if (cur_cmd == cmd_col_addr && arg_idx == 1) win_xs = {arg_hi, lcd_data[7:0]};
				else if (cur_cmd == cmd_col_addr) win_xe = {arg_hi, lcd_data[7:0]};
				else if (arg_idx == 1) win_ys = {arg_hi, lcd_data[7:0]};
				else win_ye = {arg_hi, lcd_data[7:0]};
				arg_idx++;
			end
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic fill_ram();
		logic [7:0] v;
		for (int a = 0; a < 16384; a++) begin
			for (int k = 0; k < 16; k++) begin
				lfsr = lfsr_step(lfsr);
				v = {v[6:0], lfsr[0]};
				if (k == 7) ram_a[a] = v;
			end
			ram_b[a] = v;
		end
	endtask

	function automatic logic [127:0] glyph_bits(input logic [7:0] ch);
		case (ch)
			".": return 128'h00000000_00000000_00000000_60600000;
			"1": return 128'h00000008_38080808_08080808_083E0000;
			"2": return 128'h0000003C_42424202_04081020_427E0000;
			"C": return 128'h0000003E_42428080_80808042_44380000;
			"H": return 128'h000000E7_42424242_7E424242_42E70000;
			"V": return 128'h000000E7_42424424_24282818_10100000;
			default: return '0;
		endcase
	endfunction

	function automatic logic [15:0] plot_color(input int px, input int row, input int ya,
			input int yb);
		if (row == ya) return col_yellow;
		if (row == yb) return col_blue;
		if (px % 200 == 0 || row == 0 || row == 127 || row == 255) return col_white;
		if (px % 50 == 0 || row % 32 == 31) return col_grey;
		return col_black;
	endfunction

	task automatic stop_on_failure();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_eq(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic wait_words(input int n, input int limit);
		int i;
		i = 0;
		while (bus_words.size() < n) begin
			if (i == limit) begin
				$display("timeout in %s: %0d bus words seen, %0d expected",
					test_name, bus_words.size(), n);
				stop_on_failure();
			end
			@(negedge clk);
			i++;
		end
	endtask

	task automatic check_text(input logic [55:0] s, input int len, input int x, input int y);
		logic [7:0] ch;
		logic [127:0] g;
		for (int i = 0; i < len; i++) begin
			ch = s[8 * (len - 1 - i) +: 8];
			g = glyph_bits(ch);
			for (int r = 0; r < 16; r++) begin
				for (int b = 0; b < 8; b++) begin
					check_eq($sformatf("char %0d pixel %0d,%0d", i, x + 8 * i + b, y + r),
						g[127 - 8 * r - b] ? col_white : col_black,
						screen[(y + r) * 512 + x + 8 * i + b]);
				end
			end
		end
	endtask

	task automatic test_power_up();
		int n;
		test_name = "power_up";
		check_eq("cs after reset", 1, lcd_cs);
		check_eq("wr after reset", 1, lcd_wr);
		check_eq("rd after reset", 1, lcd_rd);
		check_eq("dc after reset", 1, lcd_dc);
		check_eq("data after reset", 0, lcd_data);
		check_eq("res after reset", 1, lcd_res);
		check_eq("ram_en after reset", 0, ram_en);
		check_eq("display_done after reset", 0, display_done);
		n = 0;
		while (lcd_res !== 1'b0) begin
			if (n == 50) begin
				$display("timeout: panel reset never went low");
				stop_on_failure();
			end
			@(negedge clk);
			n++;
		end
		n = 0;
		while (lcd_res !== 1'b1) begin
			if (n == 100) begin
				$display("timeout: panel reset stuck low");
				stop_on_failure();
			end
			@(negedge clk);
			n++;
		end
		check_eq("reset low cycles", 20, n);
		check_eq("words during reset", 0, bus_words.size());
		wait_words(64, 3000);
		for (int k = 0; k < 64; k++) begin
			check_eq($sformatf("init word %0d", k),
				{init_table[k][8], 8'h00, init_table[k][7:0]}, bus_words.pop_front());
		end
	endtask

	task automatic test_clear();
		logic [16:0] addr_words [11];
		int pixels;
		test_name = "clear";
		// 0..480 by 0..320, high byte first
		addr_words = '{17'h0002a, 17'h10000, 17'h10000, 17'h10001, 17'h100e0,
			17'h0002b, 17'h10000, 17'h10000, 17'h10001, 17'h10040, 17'h0002c};
		pixels = 153600 + 480;
		wait_words(11, 200);
		for (int k = 0; k < 11; k++) begin
			check_eq($sformatf("address word %0d", k), addr_words[k], bus_words.pop_front());
		end
		wait_words(pixels, pixels * 12);
		for (int k = 0; k < pixels; k++) begin
			check_eq("pixel word", {1'b1, col_black}, bus_words.pop_front());
		end
	endtask

	task automatic test_label();
		test_name = "label";
		wait_words(1, 100);
		check_eq("first word after clear", 17'h0002a, bus_words[0]); // no extra clear pixels
		wait_words(7 * 139, 7 * 139 * 12);
		check_text("CH1 CH2", 7, 402, 5);
		bus_words.delete();
	endtask

	task automatic test_frame(input ram_addr_t trig, input logic [15:0] stp,
			input logic [47:0] txt, input string name);
		int n;
		int addr;
		int ya;
		int yb;
		test_name = name;
		fill_ram(); // fresh samples for every request
		@(negedge clk);
		trig_pos = trig;
		step = stp;
		value_text = txt;
		display_en = 1'b1;
		n = 0;
		while (ram_en !== 1'b1) begin
			if (n == 50) begin
				$display("timeout: capture RAM never enabled after the display request");
				stop_on_failure();
			end
			@(negedge clk);
			n++;
		end
		display_en = 1'b0;
		n = 0;
		while (display_done !== 1'b1) begin
			if (n == 2000000) begin
				$display("timeout: display_done never pulsed");
				stop_on_failure();
			end
			@(negedge clk);
			n++;
		end
		@(negedge clk);
		check_eq("display_done width", 0, display_done);
		check_eq("ram_en after frame", 0, ram_en);
		check_eq("bus words in frame", 401 * 267 + 6 * 139, bus_words.size());
		for (int c = 1; c <= 401; c++) begin
			addr = (int'(trig) - 201 * int'(stp) + (c - 1) * int'(stp)) & 16383;
			ya = 255 - int'(ram_a[addr]);
			yb = 255 - int'(ram_b[addr]);
			for (int r = 0; r < 256; r++) begin
				check_eq($sformatf("column %0d row %0d", c, r), plot_color(c - 1, r, ya, yb),
					screen[r * 512 + c]);
			end
		end
		check_text({8'h00, txt}, 6, 402, 42);
		check_text("CH1 CH2", 7, 402, 5);
		bus_words.delete();
	endtask

	initial begin
		rst_n = 1'b0;
		display_en = 1'b0;
		trig_pos = '0;
		step = '0;
		value_text = '0;
		for (int i = 0; i < 262144; i++) screen[i] = 16'(i ^ (i >> 7)) ^ 16'hc3a5;
		fill_ram();
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		test_power_up();
		test_clear();
		test_label();
		test_frame(14'd100, 16'd3, "12.1 V", "frame_one");
		test_frame(14'h3f00, 16'd40, "-2.2CH", "frame_two"); // both wrap the RAM
		if (dut.u_bus.u_asserts.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("bus protocol assertions failed");
			stop_on_failure();
		end
	end

endmodule

/* src.f */
+incdir+include
hdl/scope_lcd_pkg.sv
hdl/lcd_bus_writer.sv
hdl/lcd_power_up.sv
hdl/lcd_window_writer.sv
hdl/glyph_renderer.sv
hdl/wave_plotter.sv
hdl/display_sequencer.sv
hdl/scope_lcd_top.sv
tests/scope_lcd_asserts.sv
tests/tb_scope_lcd.sv

/* run_sim.sh */
#!/bin/sh
# build and run the scope LCD testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_scope_lcd -Mdir obj_dir -o sim_scope_lcd > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_scope_lcd +verilator+error+limit+100 > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status, see sim.log"
	exit 1
fi

if grep -q "Done: no errors" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL, see sim.log"
	exit 1
fi
